/* hdl/link_params.svh */
//**********************************************************************
// Timing and sizing macros for the board-to-board game link.
// Included by the UART blocks and the testbench that checks them.
//**********************************************************************

`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// clocks per serial bit, 4 or more
`define LINK_CLKS_PER_BIT 4

// log2 of the receive FIFO depth
`define LINK_FIFO_AW 2

`endif

/* hdl/link_pkg.sv */
//**********************************************************************
// Shared types of the game link: opcodes, the one-byte message format,
// request structs of the three senders and the decoded peer state.
//**********************************************************************

package link_pkg;

    typedef enum logic [2:0] {
        OP_SYNC      = 3'd0,
        OP_KEEP_LO   = 3'd1,
        OP_KEEP_HI   = 3'd2,
        OP_SHOT_X_LO = 3'd3,
        OP_SHOT_X_HI = 3'd4,
        OP_SHOT_Y_LO = 3'd5,
        OP_SHOT_Y_HI = 3'd6,
        OP_STATUS    = 3'd7
    } link_opcode_t;

    typedef struct packed {
        logic [4:0]   payload;      // one half of a 10-bit position
        link_opcode_t opcode;
    } link_pos_t;

    typedef struct packed {
        logic         role;         // sender is the shooter
        logic         start_done;   // game start in sync, shot done in status
        logic [2:0]   low;          // 001 marker or score
        link_opcode_t opcode;
    } link_stat_t;

    // one link byte, read as position half or as status fields
    typedef union packed {
        link_pos_t  pos;
        link_stat_t stat;
    } link_byte_u;

    typedef struct packed {
        link_byte_u data;
        logic       last;           // final byte of a frame
    } tx_byte_t;

    typedef struct packed {
        logic [9:0] pos;
    } keeper_req_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } shot_req_t;

    typedef enum logic {
        ST_SYNC  = 1'b0,
        ST_SCORE = 1'b1
    } status_kind_t;

    typedef struct packed {
        status_kind_t kind;
        logic         shooter;
        logic         game_starts;
        logic [2:0]   score;
        logic         shot_done;
    } status_req_t;

    typedef struct packed {
        logic       connected;
        logic       enemy_shooter;
        logic       game_starts;
        logic       shot_done;
        logic [9:0] keeper_pos;
        logic [9:0] x_shooter;
        logic [9:0] y_shooter;
        logic [2:0] opponent_score;
    } peer_state_t;

endpackage

/* hdl/uart_tx.sv */
//**********************************************************************
// 8N1 UART serializer. Takes one byte per valid/ready handshake and
// keeps ready low until the stop bit has left the txd pin.
//**********************************************************************

`timescale 1ns/1ps
`include "link_params.svh"

module uart_tx import link_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  tx_byte_t tx_data,
    input  logic     tx_valid,
    output logic     tx_ready,
    output logic     txd
);

    localparam int CPB = `LINK_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    logic          busy;
    logic [9:0]    shreg;       // stop, data lsb first, start
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;
    logic          bit_end;

    assign bit_end = (clk_cnt == CW'(CPB - 1));
    assign txd     = busy ? shreg[0] : 1'b1;   // line idles high

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            tx_ready <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            tx_ready <= 1'b1;
            if (tx_ready && tx_valid) begin
                busy     <= 1'b1;
                tx_ready <= 1'b0;
                clk_cnt  <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin  // end of stop bit
                busy     <= 1'b0;
                tx_ready <= 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && tx_ready && tx_valid) begin
            shreg <= {1'b1, tx_data.data, 1'b0};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

endmodule

/* hdl/uart_rx.sv */
//**********************************************************************
// 8N1 UART deserializer with a small receive FIFO. The head byte shows
// on read_data while rx_empty is low; a one-cycle rd_uart pops it.
//**********************************************************************

`timescale 1ns/1ps
`include "link_params.svh"

module uart_rx import link_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    input  logic       rd_uart,
    output link_byte_u read_data,
    output logic       rx_empty
);

    localparam int CPB   = `LINK_CLKS_PER_BIT;
    localparam int CW    = $clog2(CPB);
    localparam int AW    = `LINK_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t     state;
    logic          rx_meta, rx_sync;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shreg;
    logic          bit_end, fifo_full, wr_en;
    logic [AW:0]   wr_ptr, rd_ptr;   // extra msb tells full from empty
    link_byte_u    mem [DEPTH];

    assign bit_end = (clk_cnt == CW'(CPB - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: if (clk_cnt == CW'(CPB / 2 - 1)) begin  // middle of start bit
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;       // glitch, back to idle
                end
                RX_DATA: if (bit_end) begin
                    clk_cnt <= '0;
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    clk_cnt <= '0;
                    state   <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shreg <= {rx_sync, shreg[7:1]};   // lsb arrives first
        end
    end

    assign fifo_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign rx_empty  = (wr_ptr == rd_ptr);
    assign wr_en     = (state == RX_STOP) && bit_end && rx_sync && !fifo_full;
    assign read_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= shreg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_uart && !rx_empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* hdl/frame_arbiter.sv */
//**********************************************************************
// Shares the serializer between pose and status senders. A granted
// sender keeps the line until its last byte, then the other one gets
// a turn if it is waiting.
//**********************************************************************

`timescale 1ns/1ps

module frame_arbiter import link_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  tx_byte_t pose_byte,
    input  logic     pose_valid,
    input  tx_byte_t stat_byte,
    input  logic     stat_valid,
    input  logic     tx_ready,
    output logic     pose_ready,
    output logic     stat_ready,
    output tx_byte_t tx_data,
    output logic     tx_valid
);

    logic grant;        // 0 pose, 1 status; also the last winner
    logic frame_open;
    logic cur_valid, other_valid, xfer;

    assign cur_valid   = grant ? stat_valid : pose_valid;
    assign other_valid = grant ? pose_valid : stat_valid;

    assign tx_data    = grant ? stat_byte : pose_byte;
    assign tx_valid   = cur_valid;
    assign pose_ready = !grant && tx_ready;
    assign stat_ready = grant && tx_ready;
    assign xfer       = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant      <= 1'b0;
            frame_open <= 1'b0;
        end else if (xfer) begin
            frame_open <= !tx_data.last;
            if (tx_data.last && other_valid) begin
                grant <= !grant;    // round robin at frame end
            end
        end else if (!frame_open && !cur_valid && other_valid) begin
            grant <= !grant;        // idle owner, hand over
        end
    end

endmodule

/* hdl/pose_sender.sv */
//**********************************************************************
// Turns keeper and shot requests into opcode-tagged byte frames.
// Keeper is two bytes, shot is four; last marks the frame end.
//**********************************************************************

`timescale 1ns/1ps

module pose_sender import link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  keeper_req_t keeper_req,
    input  logic        keeper_valid,
    input  shot_req_t   shot_req,
    input  logic        shot_valid,
    input  logic        out_ready,
    output logic        keeper_ready,
    output logic        shot_ready,
    output tx_byte_t    out_byte,
    output logic        out_valid
);

    logic       rdy, busy, is_shot;
    logic [1:0] idx;            // byte index within frame
    logic [9:0] a_pos, b_pos;   // keeper or x, then y
    logic [9:0] cur;

    assign keeper_ready = rdy;
    assign shot_ready   = rdy && !keeper_valid;   // keeper goes first
    assign out_valid    = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy     <= 1'b0;
            busy    <= 1'b0;
            is_shot <= 1'b0;
            idx     <= '0;
        end else if (!busy) begin
            rdy <= 1'b1;
            idx <= '0;
            if (rdy && (keeper_valid || shot_valid)) begin
                rdy     <= 1'b0;
                busy    <= 1'b1;
                is_shot <= !keeper_valid;
            end
        end else if (out_ready) begin
            idx <= idx + 2'd1;
            if (out_byte.last) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && rdy) begin
            a_pos <= keeper_valid ? keeper_req.pos : shot_req.x;
            b_pos <= shot_req.y;
        end
    end

    assign cur = idx[1] ? b_pos : a_pos;

    always_comb begin
        out_byte.data.pos.payload = idx[0] ? cur[9:5] : cur[4:0];
        if (!is_shot) begin
            out_byte.data.pos.opcode = idx[0] ? OP_KEEP_HI : OP_KEEP_LO;
            out_byte.last            = idx[0];
        end else begin
            case (idx)
                2'd0:    out_byte.data.pos.opcode = OP_SHOT_X_LO;
                2'd1:    out_byte.data.pos.opcode = OP_SHOT_X_HI;
                2'd2:    out_byte.data.pos.opcode = OP_SHOT_Y_LO;
                default: out_byte.data.pos.opcode = OP_SHOT_Y_HI;
            endcase
            out_byte.last = (idx == 2'd3);
        end
    end

endmodule

/* hdl/status_sender.sv */
//**********************************************************************
// Formats sync and score requests into single status bytes and holds
// each one until the arbiter takes it.
//**********************************************************************

`timescale 1ns/1ps

module status_sender import link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  status_req_t status_req,
    input  logic        status_valid,
    input  logic        out_ready,
    output logic        status_ready,
    output tx_byte_t    out_byte,
    output logic        out_valid
);

    logic       full;
    link_byte_u held;

    assign out_valid     = full;
    assign out_byte.data = held;
    assign out_byte.last = 1'b1;    // always a one-byte frame

    always_ff @(posedge clk) begin
        if (rst) begin
            full         <= 1'b0;
            status_ready <= 1'b0;
        end else if (full) begin
            if (out_ready) full <= 1'b0;
        end else if (status_ready && status_valid) begin
            full         <= 1'b1;
            status_ready <= 1'b0;
        end else begin
            status_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!full && status_ready && status_valid) begin
            held.stat.role <= status_req.shooter;
            if (status_req.kind == ST_SYNC) begin
                held.stat.start_done <= status_req.game_starts;
                held.stat.low        <= 3'b001;   // link-ok marker
                held.stat.opcode     <= OP_SYNC;
            end else begin
                held.stat.start_done <= status_req.shot_done;
                held.stat.low        <= status_req.score;
                held.stat.opcode     <= OP_STATUS;
            end
        end
    end

endmodule

/* hdl/uart_decoder.sv */
//**********************************************************************
// Decodes received link bytes into the opponent's state. Each byte is
// decoded once and popped by a one-cycle rd_uart pulse; positions
// change only when their high half arrives.
//**********************************************************************

`timescale 1ns/1ps

module uart_decoder import link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  link_byte_u  read_data,
    input  logic        rx_empty,
    output logic        rd_uart,
    output peer_state_t peer
);

    logic [4:0] keeper_lo, x_lo, x_hi, y_lo;   // halves waiting for frame end
    logic       take;

    assign take = !rx_empty && !rd_uart;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_uart <= 1'b0;
            peer    <= '0;
        end else begin
            rd_uart <= take;    // pops the byte decoded now
            if (take) begin
                case (read_data.pos.opcode)
                    OP_SYNC: begin
                        case (read_data.pos.payload)
                            5'b11001: begin
                                peer.connected     <= 1'b1;
                                peer.enemy_shooter <= 1'b1;
                                peer.game_starts   <= 1'b1;
                            end
                            5'b01001: begin
                                peer.connected     <= 1'b1;
                                peer.enemy_shooter <= 1'b0;
                                peer.game_starts   <= 1'b1;
                            end
                            5'b00001: begin
                                peer.connected     <= 1'b1;
                                peer.enemy_shooter <= 1'b0;
                                peer.game_starts   <= 1'b0;
                            end
                            default: begin  // corrupt sync, link not trusted
                                peer.connected     <= 1'b0;
                                peer.enemy_shooter <= 1'b0;
                                peer.game_starts   <= 1'b0;
                            end
                        endcase
                    end
                    OP_KEEP_HI: peer.keeper_pos <= {read_data.pos.payload, keeper_lo};
                    OP_SHOT_Y_HI: begin
                        peer.x_shooter <= {x_hi, x_lo};
                        peer.y_shooter <= {read_data.pos.payload, y_lo};
                    end
                    OP_STATUS: begin
                        peer.opponent_score <= read_data.stat.low;
                        peer.shot_done      <= read_data.stat.start_done;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (read_data.pos.opcode)
                OP_KEEP_LO:   keeper_lo <= read_data.pos.payload;
                OP_SHOT_X_LO: x_lo      <= read_data.pos.payload;
                OP_SHOT_X_HI: x_hi      <= read_data.pos.payload;
                OP_SHOT_Y_LO: y_lo      <= read_data.pos.payload;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/game_link.sv */
//**********************************************************************
// Top of the game link. Senders share one UART transmitter through
// the frame arbiter; the receive side decodes the peer's bytes.
//**********************************************************************

`timescale 1ns/1ps

module game_link import link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  keeper_req_t keeper_req,
    input  logic        keeper_valid,
    input  shot_req_t   shot_req,
    input  logic        shot_valid,
    input  status_req_t status_req,
    input  logic        status_valid,
    input  logic        rxd,
    output logic        keeper_ready,
    output logic        shot_ready,
    output logic        status_ready,
    output logic        txd,
    output peer_state_t peer
);

    tx_byte_t   pose_byte, stat_byte, tx_data;
    logic       pose_valid, pose_ready, stat_valid, stat_ready;
    logic       tx_valid, tx_ready;
    link_byte_u read_data;
    logic       rx_empty, rd_uart;

    pose_sender pose_sender_inst (
        .clk, .rst,
        .keeper_req, .keeper_valid, .keeper_ready,
        .shot_req, .shot_valid, .shot_ready,
        .out_byte(pose_byte), .out_valid(pose_valid), .out_ready(pose_ready)
    );

    status_sender status_sender_inst (
        .clk, .rst,
        .status_req, .status_valid, .status_ready,
        .out_byte(stat_byte), .out_valid(stat_valid), .out_ready(stat_ready)
    );

    frame_arbiter frame_arbiter_inst (
        .clk, .rst,
        .pose_byte, .pose_valid, .pose_ready,
        .stat_byte, .stat_valid, .stat_ready,
        .tx_data, .tx_valid, .tx_ready
    );

    uart_tx uart_tx_inst (
        .clk, .rst, .tx_data, .tx_valid, .tx_ready, .txd
    );

    uart_rx uart_rx_inst (
        .clk, .rst, .rxd, .rd_uart, .read_data, .rx_empty
    );

    uart_decoder uart_decoder_inst (
        .clk, .rst, .read_data, .rx_empty, .rd_uart, .peer
    );

endmodule

/* tb/game_link_chk.sv */
//**********************************************************************
// Protocol assertions of the game link, bound into the frame arbiter
// and the UART decoder. Ports a target lacks are tied inactive.
//**********************************************************************

`timescale 1ns/1ps

module game_link_chk import link_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     grant,
    input logic     frame_open,
    input tx_byte_t tx_data,
    input logic     tx_valid,
    input logic     tx_ready,
    input logic     rd_uart,
    input logic     rx_empty
);

    logic frame_end;

    assign frame_end = tx_valid && tx_ready && tx_data.last;

    // no interleaving of frames
    grant_locked: assert property (@(posedge clk) disable iff (rst)
        frame_open && !frame_end |=> $stable(grant))
        else $error("arbiter grant moved while a frame was open");

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else $error("tx byte dropped or changed before tx_ready");

    pop_single: assert property (@(posedge clk) disable iff (rst)
        rd_uart |=> !rd_uart)
        else $error("rd_uart high on two cycles in a row");

    pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        rx_empty && !rd_uart |=> !rd_uart)
        else $error("rd_uart rose while the receive FIFO was empty");

endmodule

bind frame_arbiter game_link_chk arb_chk (
    .clk(clk), .rst(rst), .grant(grant), .frame_open(frame_open),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .rd_uart(1'b0), .rx_empty(1'b1)
);

bind uart_decoder game_link_chk dec_chk (
    .clk(clk), .rst(rst), .grant(1'b0), .frame_open(1'b0),
    .tx_data(9'd0), .tx_valid(1'b0), .tx_ready(1'b1),
    .rd_uart(rd_uart), .rx_empty(rx_empty)
);

/* tb/game_link_tb.sv */
//**********************************************************************
// Testbench of the game link. Loops txd back to rxd, sends keeper,
// shot and status requests and checks the decoded peer state against
// a model kept from the link rules. Raw bytes can be forced on rxd.
//**********************************************************************

`timescale 1ns/1ps
`include "link_params.svh"

module game_link_tb import link_pkg::*; ();

    localparam int CPB     = `LINK_CLKS_PER_BIT;
    localparam int CHAR    = 10 * CPB;      // clocks per character on the line
    localparam int TIMEOUT = 16 * CHAR;

    logic        clk, rst, rxd, txd;
    logic        keeper_valid, shot_valid, status_valid;
    logic        keeper_ready, shot_ready, status_ready;
    logic        raw_mode, raw_line;
    keeper_req_t keeper_req;
    shot_req_t   shot_req;
    status_req_t status_req;
    peer_state_t peer, want, prev;          // dut output, model, model before the test
    int          err_cnt, test_base, tests_run, tests_failed, stall, i;

    assign rxd = raw_mode ? raw_line : txd;     // loopback unless a raw byte is sent

    game_link game_link_inst (
        .clk, .rst, .keeper_req, .keeper_valid, .shot_req, .shot_valid,
        .status_req, .status_valid, .rxd, .keeper_ready, .shot_ready,
        .status_ready, .txd, .peer
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // connected, enemy_shooter and game_starts per sync payload
    function automatic logic [2:0] sync_flags(input logic [4:0] payload);
        case (payload)
            5'b11001: return 3'b111;
            5'b01001: return 3'b101;
            5'b00001: return 3'b100;
            default:  return 3'b000;
        endcase
    endfunction

    function automatic logic [9:0] pick_new_pos(input logic [9:0] old);
        logic [9:0] r;
        r = 10'($urandom());
        if (r == old) r = ~r;   // always a visible change
        return r;
    endfunction

    task automatic start_test();
        test_base = err_cnt;
        prev      = want;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_base) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end
    endtask

    // raise the chosen valids and drop each one after its transfer
    task automatic push_requests(input logic k, input logic s, input logic st);
        int   n;
        logic tk, ts, tst;
        keeper_valid = k;
        shot_valid   = s;
        status_valid = st;
        n = 0;
        while ((keeper_valid || shot_valid || status_valid) && n < TIMEOUT) begin
            @(negedge clk);
            tk  = keeper_valid && keeper_ready;
            ts  = shot_valid && shot_ready;
            tst = status_valid && status_ready;
            @(posedge clk);
            #2;
            if (tk) keeper_valid = 1'b0;
            if (ts) shot_valid = 1'b0;
            if (tst) status_valid = 1'b0;
            n++;
        end
        if (keeper_valid || shot_valid || status_valid) begin
            $display("timeout: a request was not accepted within %0d cycles", TIMEOUT);
            err_cnt++;
            keeper_valid = 1'b0;
            shot_valid   = 1'b0;
            status_valid = 1'b0;
        end
    endtask

    task automatic expect_peer(input string what);
        int n;
        n = 0;
        while (peer != want && n < TIMEOUT) begin
            @(negedge clk);
            // x and y of a shot land on the same cycle
            assert (!(want.x_shooter != prev.x_shooter && want.y_shooter != prev.y_shooter
                      && peer.x_shooter == want.x_shooter && peer.y_shooter == prev.y_shooter))
            else begin
                $display("error at %0t: %s shot x updated ahead of y", $time, what);
                err_cnt++;
            end
            n++;
        end
        if (peer != want) begin
            $display("timeout: %s, peer state not reached within %0d cycles", what, TIMEOUT);
            err_cnt++;
        end
        assert (peer == want)
        else begin
            $display("error at %0t: %s peer %p, expected %p", $time, what, peer, want);
            err_cnt++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic send_raw_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         k;
        frame    = {1'b1, b, 1'b0};    // stop, data lsb first, start
        raw_mode = 1'b1;
        for (k = 0; k < 10; k++) begin
            raw_line = frame[k];
            repeat (CPB) @(posedge clk);
            #2;
        end
        raw_mode = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h399e));
        rst          = 1'b1;
        keeper_valid = 1'b0;
        shot_valid   = 1'b0;
        status_valid = 1'b0;
        keeper_req   = '0;
        shot_req     = '0;
        status_req   = '0;
        raw_mode     = 1'b0;
        raw_line     = 1'b1;
        want         = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test();
        expect_peer("reset");
        end_test("reset state");

        start_test();
        keeper_req.pos  = pick_new_pos(want.keeper_pos);
        want.keeper_pos = keeper_req.pos;
        push_requests(1'b1, 1'b0, 1'b0);
        expect_peer("keeper");
        end_test("keeper loopback");

        start_test();
        shot_req.x     = pick_new_pos(want.x_shooter);
        shot_req.y     = pick_new_pos(want.y_shooter);
        want.x_shooter = shot_req.x;
        want.y_shooter = shot_req.y;
        push_requests(1'b0, 1'b1, 1'b0);
        expect_peer("shot");
        end_test("shot loopback");

        start_test();
        for (i = 0; i < 3; i++) begin   // 11, 01, 00 of shooter and game_starts
            prev                   = want;
            status_req             = '0;
            status_req.kind        = ST_SYNC;
            status_req.shooter     = (i == 0);
            status_req.game_starts = (i < 2);
            {want.connected, want.enemy_shooter, want.game_starts} =
                sync_flags({status_req.shooter, status_req.game_starts, 3'b001});
            push_requests(1'b0, 1'b0, 1'b1);
            expect_peer("sync");
        end
        prev = want;
        {want.connected, want.enemy_shooter, want.game_starts} = sync_flags(5'b10101);
        send_raw_byte({5'b10101, OP_SYNC});
        expect_peer("raw sync");
        end_test("sync decoding");

        start_test();
        status_req           = '0;
        status_req.kind      = ST_SCORE;
        status_req.score     = want.opponent_score + 3'(1 + $urandom_range(6));
        status_req.shot_done = 1'b1;
        want.opponent_score  = status_req.score;
        want.shot_done       = 1'b1;
        push_requests(1'b0, 1'b0, 1'b1);
        expect_peer("score");
        end_test("score byte");

        start_test();
        keeper_req.pos       = pick_new_pos(want.keeper_pos);
        shot_req.x           = pick_new_pos(want.x_shooter);
        shot_req.y           = pick_new_pos(want.y_shooter);
        status_req.score     = want.opponent_score + 3'(1 + $urandom_range(6));
        status_req.shot_done = 1'b0;
        want.keeper_pos      = keeper_req.pos;
        want.x_shooter       = shot_req.x;
        want.y_shooter       = shot_req.y;
        want.opponent_score  = status_req.score;
        want.shot_done       = 1'b0;
        push_requests(1'b1, 1'b1, 1'b1);    // all three on one cycle
        expect_peer("contention");
        end_test("contention");

        start_test();
        shot_req.x     = pick_new_pos(want.x_shooter);
        shot_req.y     = pick_new_pos(want.y_shooter);
        want.x_shooter = shot_req.x;
        want.y_shooter = shot_req.y;
        push_requests(1'b0, 1'b1, 1'b0);
        keeper_req.pos  = pick_new_pos(want.keeper_pos);
        want.keeper_pos = keeper_req.pos;
        keeper_valid    = 1'b1;
        stall           = 0;
        while (!keeper_ready && stall < TIMEOUT) begin
            @(negedge clk);
            if (!keeper_ready) stall++;
        end
        if (stall >= TIMEOUT) begin
            $display("timeout: keeper_ready never rose after the shot frame");
            err_cnt++;
        end
        // three earlier shot bytes must leave the line first
        assert (stall >= 3 * CHAR)
        else begin
            $display("error at %0t: keeper_ready rose after %0d cycles, shot frame open",
                     $time, stall);
            err_cnt++;
        end
        @(posedge clk);
        #2;
        keeper_valid = 1'b0;    // taken on that edge
        expect_peer("back-pressure");
        end_test("back-pressure");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/link_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/frame_arbiter.sv
hdl/pose_sender.sv
hdl/status_sender.sv
hdl/uart_decoder.sv
hdl/game_link.sv
tb/game_link_chk.sv
tb/game_link_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f compile.f --top-module game_link_tb -o game_link_sim \
    && ./obj_dir/game_link_sim | tee /dev/stderr | grep -q "^Test OK$" \
    && echo PASS || { echo FAIL; exit 1; }
